/* logic/isa_pkg.sv */
package isa_pkg;

    // RV32I major opcodes handled by this core
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        PASS_B  // Operand B straight through, used by LUI
    } alu_op_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_WORD    = 3'b010;  // LW and SW
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

    // Same fetched word, viewed per format
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_u_t u;
    } instr_u;

    // ADDI x0, x0, 0
    localparam logic [31:0] nop_instr = {12'd0, 5'd0, F3_ADD_SUB, 5'd0, OP_IMM};

endpackage

/* logic/pipe_pkg.sv */
package pipe_pkg;

    // Upper three address bits pick the target
    typedef enum logic [2:0] {
        RAM  = 3'b000,
        GPIO = 3'b001,
        PWM  = 3'b010
    } dest_e;

    function automatic dest_e addr_dest(logic [31:0] addr);
        return dest_e'(addr[31:29]);
    endfunction

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                 valid;
        logic [31:0]          rs1_value;
        logic [31:0]          rs2_value;
        logic [31:0]          imm;
        isa_pkg::alu_op_e     alu_op;
        logic                 alu_src_imm;  // Operand B from immediate
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
        logic [4:0]           rd;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic [31:0] store_data;
        logic        mem_read;
        logic        mem_write;
        logic        reg_write;
        logic [4:0]  rd;
    } ex_mem_t;

    // Register bank write request
    typedef struct packed {
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } bus_t;

endpackage

/* logic/register_bank.sv */
`timescale 1ns/10ps

module register_bank (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          enable,
    input  logic [4:0]    rs1_addr,
    input  logic [4:0]    rs2_addr,
    output logic [31:0]   rs1_value,
    output logic [31:0]   rs2_value,
    input  pipe_pkg::wb_t wb
);

    logic [31:0] regs [32];
    logic        wr_hit;

    assign wr_hit = enable && wb.reg_write && (wb.rd != 5'd0);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write-through so decode sees a value written this cycle
    always_comb begin
        rs1_value = (wr_hit && rs1_addr == wb.rd) ? wb.data : regs[rs1_addr];
        rs2_value = (wr_hit && rs2_addr == wb.rd) ? wb.data : regs[rs2_addr];
        if (rs1_addr == 5'd0) rs1_value = '0;
        if (rs2_addr == 5'd0) rs2_value = '0;
    end

endmodule

/* logic/cpu_fetch.sv */
`timescale 1ns/10ps

module cpu_fetch (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             enable,
    input  logic [31:0]      rom_data,
    output logic [31:0]      rom_address,
    output pipe_pkg::if_id_t if_id
);

    logic [31:0] pc;

    assign rom_address = pc;  // ROM answers in the same cycle

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (enable) begin
            pc <= pc + 32'd4;  // No branches, straight-line only
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            if_id <= '{valid: 1'b0, pc: '0, instr: isa_pkg::nop_instr};
        end else if (enable) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= rom_data;
        end
    end

endmodule

/* logic/cpu_decode.sv */
`timescale 1ns/10ps

module cpu_decode (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             enable,
    input  pipe_pkg::if_id_t if_id,
    output logic [4:0]       rs1_addr,
    output logic [4:0]       rs2_addr,
    input  logic [31:0]      rs1_value,
    input  logic [31:0]      rs2_value,
    output pipe_pkg::id_ex_t id_ex
);

    isa_pkg::instr_u  ins;
    pipe_pkg::id_ex_t nxt;
    logic [31:0]      imm_i;
    logic [31:0]      imm_s;
    logic [31:0]      imm_u;

    assign ins = if_id.instr;

    // Field positions of rs1/rs2 are shared by R, I and S formats
    assign rs1_addr = ins.r.rs1;
    assign rs2_addr = ins.r.rs2;

    assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
    assign imm_s = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
    assign imm_u = {ins.u.imm, 12'd0};

    always_comb begin
        nxt           = '0;  // Unknown opcodes end up as no-ops
        nxt.valid     = if_id.valid;
        nxt.rs1_value = rs1_value;
        nxt.rs2_value = rs2_value;
        nxt.rd        = ins.r.rd;
        nxt.alu_op    = isa_pkg::ADD;
        case (ins.r.opcode)
            isa_pkg::OP: begin
                nxt.reg_write = (ins.r.funct7 == isa_pkg::F7_BASE);
                case (ins.r.funct3)
                    isa_pkg::F3_ADD_SUB: begin
                        if (ins.r.funct7 == isa_pkg::F7_SUB) begin
                            nxt.alu_op    = isa_pkg::SUB;
                            nxt.reg_write = 1'b1;
                        end
                    end
                    isa_pkg::F3_XOR: nxt.alu_op = isa_pkg::XOR;
                    isa_pkg::F3_OR:  nxt.alu_op = isa_pkg::OR;
                    isa_pkg::F3_AND: nxt.alu_op = isa_pkg::AND;
                    default:         nxt.reg_write = 1'b0;  // Shifts and compares
                endcase
            end
            isa_pkg::OP_IMM: begin
                nxt.imm         = imm_i;
                nxt.alu_src_imm = 1'b1;
                nxt.reg_write   = (ins.i.funct3 == isa_pkg::F3_ADD_SUB);  // ADDI only
            end
            isa_pkg::LOAD: begin
                nxt.imm         = imm_i;
                nxt.alu_src_imm = 1'b1;
                nxt.mem_read    = (ins.i.funct3 == isa_pkg::F3_WORD);
                nxt.reg_write   = (ins.i.funct3 == isa_pkg::F3_WORD);
            end
            isa_pkg::STORE: begin
                nxt.imm         = imm_s;
                nxt.alu_src_imm = 1'b1;
                nxt.mem_write   = (ins.s.funct3 == isa_pkg::F3_WORD);
            end
            isa_pkg::LUI: begin
                nxt.imm         = imm_u;
                nxt.alu_src_imm = 1'b1;
                nxt.alu_op      = isa_pkg::PASS_B;
                nxt.reg_write   = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (enable) begin
            id_ex <= nxt;
        end
    end

endmodule

/* logic/cpu_execute.sv */
`timescale 1ns/10ps

module cpu_execute (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              enable,
    input  pipe_pkg::id_ex_t  id_ex,
    output pipe_pkg::ex_mem_t ex_mem
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] result;

    assign op_a = id_ex.rs1_value;
    assign op_b = id_ex.alu_src_imm ? id_ex.imm : id_ex.rs2_value;

    // Also forms the address for LW and SW
    always_comb begin
        case (id_ex.alu_op)
            isa_pkg::ADD:    result = op_a + op_b;
            isa_pkg::SUB:    result = op_a - op_b;
            isa_pkg::AND:    result = op_a & op_b;
            isa_pkg::OR:     result = op_a | op_b;
            isa_pkg::XOR:    result = op_a ^ op_b;
            isa_pkg::PASS_B: result = op_b;
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (enable) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.result     <= result;
            ex_mem.store_data <= id_ex.rs2_value;  // SW data is always rs2
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

/* logic/cpu_memory.sv */
`timescale 1ns/10ps

module cpu_memory (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              enable,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::bus_t    bus,
    input  logic [31:0]       ram_rdata,
    output pipe_pkg::wb_t     wb
);

    logic [31:0] load_data;
    logic [31:0] wb_data;

    assign bus.addr  = ex_mem.result;
    assign bus.wdata = ex_mem.store_data;
    assign bus.we    = ex_mem.valid && ex_mem.mem_write;  // One cycle per store

    // Only RAM is readable, peripherals read back as zero
    assign load_data = (pipe_pkg::addr_dest(ex_mem.result) == pipe_pkg::RAM) ? ram_rdata : '0;

    assign wb_data = ex_mem.mem_read ? load_data : ex_mem.result;

    // Writeback stage folded in here
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (enable) begin
            wb.reg_write <= ex_mem.valid && ex_mem.reg_write;
            wb.rd        <= ex_mem.rd;
            wb.data      <= wb_data;
        end
    end

endmodule

/* logic/data_ram.sv */
`timescale 1ns/10ps

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic           clock,
    input  logic           enable,
    input  pipe_pkg::bus_t bus,
    output logic [31:0]    rdata
);

    localparam int ADDR_BITS = $clog2(RAM_WORDS);

    logic [31:0]          mem [RAM_WORDS];
    logic [ADDR_BITS-1:0] index;

    assign index = bus.addr[ADDR_BITS+1:2];  // Word index, byte offset dropped
    assign rdata = mem[index];

    always_ff @(posedge clock) begin
        if (enable && bus.we && pipe_pkg::addr_dest(bus.addr) == pipe_pkg::RAM) begin
            mem[index] <= bus.wdata;
        end
    end

endmodule

/* logic/peripheral_manager.sv */
`timescale 1ns/10ps

module peripheral_manager #(
    parameter int PWM_BITS = 8
) (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           enable,
    input  pipe_pkg::bus_t bus,
    output logic [31:0]    gpio,
    output logic           pwm_out
);

    pipe_pkg::dest_e     dest;
    logic [PWM_BITS-1:0] duty;
    logic [PWM_BITS-1:0] counter;

    assign dest = pipe_pkg::addr_dest(bus.addr);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            gpio <= '0;
            duty <= '0;
        end else if (enable && bus.we) begin
            if (dest == pipe_pkg::GPIO) gpio <= bus.wdata;
            if (dest == pipe_pkg::PWM) duty <= bus.wdata[PWM_BITS-1:0];  // Low bits only
        end
    end

    // Free-running, wraps every 2^PWM_BITS cycles
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            counter <= '0;
        end else if (enable) begin
            counter <= counter + 1'b1;
        end
    end

    // High for exactly duty counts per period
    assign pwm_out = (counter < duty);

endmodule

/* logic/cpu.sv */
`timescale 1ns/10ps

module cpu #(
    parameter int RAM_WORDS = 256,
    parameter int PWM_BITS  = 8
) (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        enable,   // Level, freezes the whole core when low
    input  logic [31:0] rom_data,
    output logic [31:0] rom_address,
    output logic [31:0] gpio,
    output logic        pwm_out
);

    // Stage boundaries
    pipe_pkg::if_id_t  if_id;
    pipe_pkg::id_ex_t  id_ex;
    pipe_pkg::ex_mem_t ex_mem;
    pipe_pkg::wb_t     wb;

    // Register bank read side
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;

    // Shared data bus, prefix picks RAM or a peripheral
    pipe_pkg::bus_t bus;
    logic [31:0]    ram_rdata;

    register_bank u_register_bank (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wb        (wb)
    );

    cpu_fetch u_fetch (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (enable),
        .rom_data    (rom_data),
        .rom_address (rom_address),
        .if_id       (if_id)
    );

    cpu_decode u_decode (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .if_id     (if_id),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .id_ex     (id_ex)
    );

    cpu_execute u_execute (
        .clock  (clock),
        .rst_n  (rst_n),
        .enable (enable),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    cpu_memory u_memory (
        .clock     (clock),
        .rst_n     (rst_n),
        .enable    (enable),
        .ex_mem    (ex_mem),
        .bus       (bus),
        .ram_rdata (ram_rdata),
        .wb        (wb)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clock  (clock),
        .enable (enable),
        .bus    (bus),
        .rdata  (ram_rdata)
    );

    peripheral_manager #(
        .PWM_BITS (PWM_BITS)
    ) u_peripheral_manager (
        .clock   (clock),
        .rst_n   (rst_n),
        .enable  (enable),
        .bus     (bus),
        .gpio    (gpio),
        .pwm_out (pwm_out)
    );

endmodule

/* tb/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam logic [6:0] OPC_OP    = 7'b0110011;
localparam logic [6:0] OPC_IMM   = 7'b0010011;
localparam logic [6:0] OPC_LOAD  = 7'b0000011;
localparam logic [6:0] OPC_STORE = 7'b0100011;
localparam logic [6:0] OPC_LUI   = 7'b0110111;

logic [31:0]         m_regs [32];
logic [31:0]         m_ram [RAM_WORDS];
logic [31:0]         m_gpio;
logic [PWM_BITS-1:0] m_duty;
logic [31:0]         exp_gpio [$];   // GPIO values in the order they should show up
logic [4:0]          recent_rd [2];  // Destinations of the last two instructions

function automatic logic [31:0] rtype_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] itype_word(logic [6:0] opc, logic [4:0] rd, logic [4:0] rs1,
                                           logic [11:0] imm);
    return {imm, rs1, (opc == OPC_LOAD) ? 3'b010 : 3'b000, rd, opc};
endfunction

function automatic logic [31:0] store_word(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, OPC_LUI};
endfunction

// Applies one instruction in program order
function automatic void execute_ref(logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic        wr;
    a     = m_regs[w[19:15]];
    b     = m_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    res   = '0;
    wr    = 1'b1;
    case (w[6:0])
        OPC_OP: begin
            case ({w[31:25], w[14:12]})
                {7'h00, 3'd0}: res = a + b;
                {7'h20, 3'd0}: res = a - b;
                {7'h00, 3'd4}: res = a ^ b;
                {7'h00, 3'd6}: res = a | b;
                {7'h00, 3'd7}: res = a & b;
                default:       wr = 1'b0;
            endcase
        end
        OPC_IMM: res = a + imm_i;
        OPC_LOAD: begin
            addr = a + imm_i;
            res  = (addr[31:29] == 3'b000) ? m_ram[(addr >> 2) % RAM_WORDS] : '0;
        end
        OPC_STORE: begin
            wr   = 1'b0;
            addr = a + imm_s;
            case (addr[31:29])
                3'b000: m_ram[(addr >> 2) % RAM_WORDS] = b;
                3'b001: begin
                    if (b != m_gpio) exp_gpio.push_back(b);  // Only changes are visible
                    m_gpio = b;
                end
                3'b010: m_duty = b[PWM_BITS-1:0];
                default: ;
            endcase
        end
        OPC_LUI: res = {w[31:12], 12'd0};
        default: wr = 1'b0;
    endcase
    if (wr && w[11:7] != 5'd0) m_regs[w[11:7]] = res;
endfunction

function automatic void append_instr(logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
    execute_ref(w);
    recent_rd[1] = recent_rd[0];
    recent_rd[0] = (w[6:0] == OPC_STORE) ? 5'd0 : w[11:7];
endfunction

function automatic logic reads_recent(logic [4:0] r);
    return (r != 5'd0) && (r == recent_rd[0] || r == recent_rd[1]);
endfunction

// Pads with NOPs until both sources are three back
function automatic void append_after_gap(logic [31:0] w, logic [4:0] s1, logic [4:0] s2);
    while (reads_recent(s1) || reads_recent(s2)) append_instr(NOP_WORD);
    append_instr(w);
endfunction

function automatic logic [4:0] pick_source();
    return 5'($urandom % 16);
endfunction

function automatic logic [4:0] pick_dest();
    if ($urandom % 8 == 0) return 5'd0;  // Write to x0 now and then
    return 5'(3 + $urandom % 13);        // x1 and x2 keep the bases
endfunction

function automatic void build_program();
    int unsigned kind;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [4:0]  rd;
    logic [11:0] offset;
    logic [6:0]  f7;
    logic [2:0]  f3;
    for (int i = 0; i < PROG_LEN; i++) rom[i] = NOP_WORD;
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    m_gpio       = '0;
    m_duty       = '0;
    prog_len     = 0;
    recent_rd[0] = 5'd0;
    recent_rd[1] = 5'd0;
    append_instr(lui_word(5'd1, 20'h20000));  // GPIO base
    append_instr(lui_word(5'd2, 20'h40000));  // PWM base
    while (prog_len < PROG_LEN - 10) begin  // Room for the longest step and the tail
        kind   = $urandom % 8;
        s1     = pick_source();
        s2     = pick_source();
        rd     = pick_dest();
        offset = 12'(($urandom % 64) * 4);
        case (kind)
            0, 1: begin
                f7 = 7'h00;
                case ($urandom % 5)
                    0: f3 = 3'd0;
                    1: begin
                        f7 = 7'h20;  // SUB
                        f3 = 3'd0;
                    end
                    2: f3 = 3'd4;
                    3: f3 = 3'd6;
                    default: f3 = 3'd7;
                endcase
                append_after_gap(rtype_word(f7, f3, rd, s1, s2), s1, s2);
            end
            2: append_after_gap(itype_word(OPC_IMM, rd, s1, 12'($urandom)), s1, 5'd0);
            3: append_instr(lui_word(rd, 20'($urandom)));
            4: begin
                // Store to RAM and load back before showing the word on GPIO
                append_after_gap(store_word(5'd0, s2, offset), 5'd0, s2);
                append_instr(itype_word(OPC_LOAD, rd, 5'd0, offset));
                append_after_gap(store_word(5'd1, rd, 12'd0), 5'd1, rd);
            end
            5, 6: append_after_gap(store_word(5'd1, s2, 12'd0), 5'd1, s2);
            default: append_after_gap(store_word(5'd2, s2, 12'd0), 5'd2, s2);
        endcase
    end
    // Final duty never zero so both PWM levels occur
    append_instr(itype_word(OPC_IMM, 5'd3, 5'd0, 12'(1 + $urandom % ((1 << PWM_BITS) - 1))));
    append_after_gap(store_word(5'd2, 5'd3, 12'd0), 5'd2, 5'd3);
endfunction

`endif

/* tb/tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu;

    localparam int          PROG_LEN    = 200;
    localparam int          RAM_WORDS   = 256;
    localparam int          PWM_BITS    = 8;
    localparam int          CLK_PERIOD  = 8;
    localparam logic [31:0] SEED        = 32'h3abb91ba;
    localparam logic [31:0] NOP_WORD    = 32'h0000_0013;  // ADDI x0, x0, 0
    localparam int          DRAIN_ADDR  = (PROG_LEN + 6) * 4;  // Pipeline empty past here
    localparam int          WATCHDOG_NS = (PROG_LEN + 50) * 4 * CLK_PERIOD;

    logic        clock;
    logic        rst_n;
    logic        enable;
    logic [31:0] rom_data;
    logic [31:0] rom_address;
    logic [31:0] gpio;
    logic        pwm_out;

    logic [31:0] rom [PROG_LEN];
    int          prog_len;
    int          errors;
    logic [31:0] last_addr;
    logic [31:0] last_gpio;

    `include "cpu_model.svh"

    cpu #(
        .RAM_WORDS (RAM_WORDS),
        .PWM_BITS  (PWM_BITS)
    ) uut (
        .clock       (clock),
        .rst_n       (rst_n),
        .enable      (enable),
        .rom_data    (rom_data),
        .rom_address (rom_address),
        .gpio        (gpio),
        .pwm_out     (pwm_out)
    );

    // Combinational ROM, NOPs past the program
    assign rom_data = (rom_address < PROG_LEN * 4) ? rom[rom_address[31:2]] : NOP_WORD;

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the program never drained", WATCHDOG_NS);
        $display("Errors: %0d", errors + 1);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Called at the falling edge, before enable is changed
    task automatic sample_outputs();
        if (!enable) begin  // Held low across the last rising edge
            check_value("rom_address while disabled", rom_address, last_addr);
            check_value("gpio while disabled", gpio, last_gpio);
        end
        if (gpio !== last_gpio) begin
            if (exp_gpio.size() == 0) begin
                errors++;
                $display("GPIO changed to %h at %0t with no write left in the model",
                         gpio, $time);
            end else begin
                check_value("gpio write", gpio, exp_gpio.pop_front());
            end
        end
        last_addr = rom_address;
        last_gpio = gpio;
    endtask

    task automatic next_cycle(input logic en_next);
        @(negedge clock);
        sample_outputs();
        enable = en_next;
    endtask

    initial begin
        int high_cycles;
        rst_n  = 1'b0;
        enable = 1'b0;
        errors = 0;
        void'($urandom(SEED));
        build_program();
        if (exp_gpio.size() == 0) begin
            errors++;
            $display("The generated program never writes GPIO");
        end

        repeat (2) @(negedge clock);
        check_value("rom_address after reset", rom_address, 32'd0);
        check_value("gpio after reset", gpio, 32'd0);
        check_value("pwm_out after reset", {31'd0, pwm_out}, 32'd0);
        last_addr = rom_address;
        last_gpio = gpio;
        rst_n     = 1'b1;
        enable    = 1'b1;

        // About a quarter of the cycles frozen
        while (rom_address < DRAIN_ADDR) begin
            next_cycle(($urandom % 4) != 0);
        end

        // One full PWM period with enable high
        next_cycle(1'b1);
        high_cycles = 0;
        repeat (2 ** PWM_BITS) begin
            next_cycle(1'b1);
            if (pwm_out) high_cycles++;
        end
        check_value("PWM high cycles per period", high_cycles, {{(32 - PWM_BITS){1'b0}}, m_duty});

        if (exp_gpio.size() != 0) begin
            errors++;
            $display("%0d expected GPIO writes never appeared", exp_gpio.size());
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+tb
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/register_bank.sv
logic/cpu_fetch.sv
logic/cpu_decode.sv
logic/cpu_execute.sv
logic/cpu_memory.sv
logic/data_ram.sv
logic/peripheral_manager.sv
logic/cpu.sv
tb/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - logic/isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/register_bank.sv
  - logic/cpu_fetch.sv
  - logic/cpu_decode.sv
  - logic/cpu_execute.sv
  - logic/cpu_memory.sv
  - logic/data_ram.sv
  - logic/peripheral_manager.sv
  - logic/cpu.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_cpu.sv
